//--- source/backend_defs.svh
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////////////////////////////////////////

// Data and address width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// Data memory depth in 32-bit words, word index is address bits 9:2
`define DMEM_WORDS 256

// Control word leaving the control module
// [11:7] dest, [6] reg write, [5:4] wb select, [3] mem access, [2:0] width
`define CTRL_W 12

`endif

//--- source/backend_pkg.sv
package backend_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings seen by the back end
    ////////////////////////////////////////////////////////////////////////////

    // Memory opcode from execute
    typedef enum logic [1:0] {
        MEM_OP_NONE  = 2'd0,  // ALU result goes to rd
        MEM_OP_LOAD  = 2'd1,
        MEM_OP_STORE = 2'd2,
        MEM_OP_NOP   = 2'd3   // no register write at all
    } mem_op_e;

    // Access width, same encoding as funct3
    typedef enum logic [2:0] {
        W_BYTE  = 3'd0,
        W_HALF  = 3'd1,
        W_WORD  = 3'd2,
        W_BYTEU = 3'd4,
        W_HALFU = 3'd5
    } width_e;

    // Writeback source
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1
    } wb_sel_e;

endpackage

//--- source/mem_control.sv
`include "backend_defs.svh"

module mem_control
    import backend_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid_i,
    input  mem_op_e                mem_op_i,
    input  width_e                 funct3_i,
    input  logic [`REG_ADDR_W-1:0] rd_i,
    input  logic [1:0]             addr_low_i,
    output logic [`CTRL_W-1:0]     ctrl_o,
    output logic                   misaligned_o,
    output logic [`XLEN-1:0]       miss_count_o
);

    logic    is_mem;
    logic    width_ok;
    logic    access;
    logic    reg_we;
    wb_sel_e wb_sel;

    // Load or store on a valid cycle
    assign is_mem = valid_i && (mem_op_i == MEM_OP_LOAD || mem_op_i == MEM_OP_STORE);
    // Reserved funct3 codes never reach the memory
    assign width_ok = funct3_i inside {W_BYTE, W_HALF, W_WORD, W_BYTEU, W_HALFU};

    // Half at odd address, word at any nonzero offset
    always_comb begin
        misaligned_o = 1'b0;
        if (is_mem) begin
            case (funct3_i)
                W_HALF, W_HALFU: misaligned_o = addr_low_i[0];
                W_WORD:          misaligned_o = (addr_low_i != 2'b00);
                default:         misaligned_o = 1'b0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        access = 1'b0;
        reg_we = 1'b0;
        wb_sel = WB_ALU;
        case (mem_op_i)
            MEM_OP_NONE: reg_we = 1'b1;
            MEM_OP_LOAD: begin
                access = 1'b1;
                reg_we = 1'b1;
                wb_sel = WB_LOAD;
            end
            MEM_OP_STORE: access = 1'b1;
            default: access = 1'b0;
        endcase
        // x0 is never written
        if (rd_i == '0) begin
            reg_we = 1'b0;
            // Otherwise access without write would decode as a store
            if (mem_op_i == MEM_OP_LOAD) begin
                access = 1'b0;
            end
        end
    end

    // Pack in reference layout, suppressed accesses become a no-op
    assign ctrl_o = (valid_i && !misaligned_o && !(is_mem && !width_ok))
                  ? {rd_i, reg_we, wb_sel, access, funct3_i}
                  : '0;

    // Count of suppressed misaligned accesses
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            miss_count_o <= '0;
        end else if (misaligned_o) begin
            miss_count_o <= miss_count_o + 1'b1;
        end
    end

    // Idle cycles must not disturb MEM, WB or the register file
    a_idle_ctrl_zero: assert property (@(posedge clk) disable iff (!reset)
        !valid_i |-> ctrl_o == '0)
        else $error("control word nonzero on an idle cycle");

endmodule

//--- source/mem_stage.sv
`include "backend_defs.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       execute_result_i,
    input  logic [`XLEN-1:0]       store_data_i,
    input  logic [`CTRL_W-1:0]     control_signal_i,
    input  logic [`XLEN-1:0]       load_data_i,
    output logic [`XLEN-1:0]       store_data_o,
    output logic [2:0]             data_mem_width_sel_o,
    output logic                   data_mem_rw_o,
    output logic [`XLEN-1:0]       execute_result_o,
    output logic [`XLEN-1:0]       load_data_o,
    output logic [`CTRL_W-2:0]     control_signal_o,
    output logic [`REG_ADDR_W-1:0] mem_stage_destination_o,
    output logic                   mem_stage_we_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Memory side, combinational in the MEM cycle
    ////////////////////////////////////////////////////////////////////////////

    assign store_data_o         = store_data_i;
    assign data_mem_width_sel_o = control_signal_i[2:0];
    // Store is access without register write
    assign data_mem_rw_o        = control_signal_i[3] & ~control_signal_i[6];

    // To hazard and forwarding logic
    assign mem_stage_destination_o = control_signal_i[11:7];
    assign mem_stage_we_o          = control_signal_i[6];

    ////////////////////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////////////////////

    // Keeps dest, we, wb select and width; the access bit is consumed here
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            execute_result_o <= '0;
            load_data_o      <= '0;
            control_signal_o <= '0;
        end else begin
            execute_result_o <= execute_result_i;
            load_data_o      <= load_data_i;
            control_signal_o <= {control_signal_i[11:4], control_signal_i[2:0]};
        end
    end

    // Write strobe and register write are exclusive
    a_strobe_vs_we: assert property (@(posedge clk) disable iff (!reset)
        data_mem_rw_o |-> !mem_stage_we_o)
        else $error("memory write strobe with register write enable");

endmodule

//--- source/data_memory.sv
`include "backend_defs.svh"

module data_memory
    import backend_pkg::*;
(
    input  logic             clk,
    input  logic [`XLEN-1:0] addr_i,
    input  logic [`XLEN-1:0] wdata_i,
    input  logic [2:0]       width_sel_i,
    input  logic             we_i,
    output logic [`XLEN-1:0] rdata_o
);

    localparam int IDX_W  = $clog2(`DMEM_WORDS);
    localparam int NBYTES = `XLEN / 8;

    // Word storage, no reset
    logic [`XLEN-1:0]  mem [`DMEM_WORDS];
    logic [IDX_W-1:0]  word_idx;
    logic [1:0]        offset;
    logic [NBYTES-1:0] byte_en;
    logic [`XLEN-1:0]  lane_data;

    // Upper address bits ignored, memory wraps
    assign word_idx = addr_i[IDX_W+1:2];
    assign offset   = addr_i[1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Byte lanes for a sized store
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (width_sel_i)
            W_BYTE, W_BYTEU: begin
                byte_en   = NBYTES'(1) << offset;
                lane_data = {{(`XLEN-8){1'b0}}, wdata_i[7:0]} << {offset, 3'b000};
            end
            W_HALF, W_HALFU: begin
                byte_en   = NBYTES'(3) << offset;
                lane_data = {{(`XLEN-16){1'b0}}, wdata_i[15:0]} << {offset, 3'b000};
            end
            W_WORD: begin
                byte_en   = '1;
                lane_data = wdata_i;
            end
            // Reserved codes write nothing
            default: begin
                byte_en   = '0;
                lane_data = wdata_i;
            end
        endcase
    end

    // Only enabled lanes change
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    // Whole word, lane pick happens in writeback
    assign rdata_o = mem[word_idx];

    // Control must never send a store with a reserved width
    a_no_reserved_write: assert property (@(posedge clk)
        we_i |-> width_sel_i inside {W_BYTE, W_HALF, W_WORD, W_BYTEU, W_HALFU})
        else $error("store with reserved width code %0d", width_sel_i);

endmodule

//--- source/writeback_stage.sv
`include "backend_defs.svh"

module writeback_stage
    import backend_pkg::*;
(
    input  logic [`XLEN-1:0]       execute_result_i,
    input  logic [`XLEN-1:0]       load_data_i,
    input  logic [`CTRL_W-2:0]     control_signal_i,
    output logic                   rf_we_o,
    output logic [`REG_ADDR_W-1:0] rf_waddr_o,
    output logic [`XLEN-1:0]       rf_wdata_o
);

    // Registered control: [10:6] dest, [5] we, [4:3] wb select, [2:0] width
    logic [2:0]       width;
    wb_sel_e          wb_sel;
    logic [`XLEN-1:0] lane_word;
    logic [`XLEN-1:0] load_value;

    assign width  = control_signal_i[2:0];
    assign wb_sel = wb_sel_e'(control_signal_i[4:3]);

    // Move addressed byte or half down to bit 0
    assign lane_word = load_data_i >> {execute_result_i[1:0], 3'b000};

    ////////////////////////////////////////////////////////////////////////////
    // Load extension
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (width)
            W_BYTE:  load_value = {{(`XLEN-8){lane_word[7]}}, lane_word[7:0]};
            W_HALF:  load_value = {{(`XLEN-16){lane_word[15]}}, lane_word[15:0]};
            W_BYTEU: load_value = {{(`XLEN-8){1'b0}}, lane_word[7:0]};
            W_HALFU: load_value = {{(`XLEN-16){1'b0}}, lane_word[15:0]};
            // Word load, offset is always zero here
            default: load_value = load_data_i;
        endcase
    end

    // Register file write port
    assign rf_we_o    = control_signal_i[5];
    assign rf_waddr_o = control_signal_i[10:6];
    assign rf_wdata_o = (wb_sel == WB_LOAD) ? load_value : execute_result_i;

endmodule

//--- source/register_file.sv
`include "backend_defs.svh"

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    input  logic [`REG_ADDR_W-1:0] raddr_a_i,
    input  logic [`REG_ADDR_W-1:0] raddr_b_i,
    output logic [`XLEN-1:0]       rdata_a_o,
    output logic [`XLEN-1:0]       rdata_b_o
);

    localparam int NREGS = 2 ** `REG_ADDR_W;

    // x1 to x31, x0 has no storage
    logic [`XLEN-1:0] regs [1:NREGS-1];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // No bypass, same-cycle read returns the old value
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

    // Control upstream already drops writes to x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (!reset)
        we_i |-> waddr_i != '0)
        else $error("register write addressed to x0");

endmodule

//--- source/mem_wb_top.sv
`include "backend_defs.svh"

module mem_wb_top
    import backend_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid_i,
    input  mem_op_e                mem_op_i,
    input  width_e                 funct3_i,
    input  logic [`REG_ADDR_W-1:0] rd_i,
    input  logic [`XLEN-1:0]       alu_result_i,
    input  logic [`XLEN-1:0]       store_data_i,
    input  logic [`REG_ADDR_W-1:0] raddr_a_i,
    input  logic [`REG_ADDR_W-1:0] raddr_b_i,
    output logic [`XLEN-1:0]       rdata_a_o,
    output logic [`XLEN-1:0]       rdata_b_o,
    output logic [`REG_ADDR_W-1:0] mem_dest_o,
    output logic                   mem_we_o,
    output logic [`REG_ADDR_W-1:0] wb_dest_o,
    output logic                   wb_we_o,
    output logic                   misaligned_o,
    output logic [`XLEN-1:0]       miss_count_o
);

    // MEM cycle
    logic [`CTRL_W-1:0] ctrl_word;
    logic [`XLEN-1:0]   dmem_wdata;
    logic [2:0]         dmem_width;
    logic               dmem_we;
    logic [`XLEN-1:0]   dmem_rdata;

    // MEM/WB register contents
    logic [`XLEN-1:0]   wb_result;
    logic [`XLEN-1:0]   wb_load;
    logic [`CTRL_W-2:0] wb_ctrl;

    // Register file write port
    logic [`XLEN-1:0]   rf_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // MEM
    ////////////////////////////////////////////////////////////////////////////
    mem_control u_mem_control (
        .clk          (clk),
        .reset        (reset),
        .valid_i      (valid_i),
        .mem_op_i     (mem_op_i),
        .funct3_i     (funct3_i),
        .rd_i         (rd_i),
        .addr_low_i   (alu_result_i[1:0]),
        .ctrl_o       (ctrl_word),
        .misaligned_o (misaligned_o),
        .miss_count_o (miss_count_o)
    );

    mem_stage u_mem_stage (
        .clk                     (clk),
        .reset                   (reset),
        .execute_result_i        (alu_result_i),
        .store_data_i            (store_data_i),
        .control_signal_i        (ctrl_word),
        .load_data_i             (dmem_rdata),
        .store_data_o            (dmem_wdata),
        .data_mem_width_sel_o    (dmem_width),
        .data_mem_rw_o           (dmem_we),
        .execute_result_o        (wb_result),
        .load_data_o             (wb_load),
        .control_signal_o        (wb_ctrl),
        .mem_stage_destination_o (mem_dest_o),
        .mem_stage_we_o          (mem_we_o)
    );

    // Address is the ALU result itself
    data_memory u_data_memory (
        .clk         (clk),
        .addr_i      (alu_result_i),
        .wdata_i     (dmem_wdata),
        .width_sel_i (dmem_width),
        .we_i        (dmem_we),
        .rdata_o     (dmem_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // WB
    ////////////////////////////////////////////////////////////////////////////
    writeback_stage u_writeback_stage (
        .execute_result_i (wb_result),
        .load_data_i      (wb_load),
        .control_signal_i (wb_ctrl),
        .rf_we_o          (wb_we_o),
        .rf_waddr_o       (wb_dest_o),
        .rf_wdata_o       (rf_wdata)
    );

    register_file u_register_file (
        .clk       (clk),
        .reset     (reset),
        .we_i      (wb_we_o),
        .waddr_i   (wb_dest_o),
        .wdata_i   (rf_wdata),
        .raddr_a_i (raddr_a_i),
        .raddr_b_i (raddr_b_i),
        .rdata_a_o (rdata_a_o),
        .rdata_b_o (rdata_b_o)
    );

endmodule

//--- verification/mem_wb_tb.sv
`include "backend_defs.svh"

module mem_wb_tb
    import backend_pkg::*;
();

    localparam int         NUM_RANDOM  = 3000;
    localparam int         DRAIN_LIMIT = 8;
    // Loads and stores stay in 64 bytes from here so loads hit stored bytes
    localparam logic [9:0] WIN_BASE    = 10'h100;

    logic                   clk;
    logic                   reset;
    logic                   valid;
    mem_op_e                mem_op;
    width_e                 funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       store_data;
    logic [`REG_ADDR_W-1:0] raddr_a;
    logic [`REG_ADDR_W-1:0] raddr_b;
    logic [`XLEN-1:0]       rdata_a;
    logic [`XLEN-1:0]       rdata_b;
    logic [`REG_ADDR_W-1:0] mem_dest;
    logic                   mem_we;
    logic [`REG_ADDR_W-1:0] wb_dest;
    logic                   wb_we;
    logic                   misaligned;
    logic [`XLEN-1:0]       miss_count;

    // Shadow state, byte memory indexed by address bits 9:0
    logic [7:0]             smem [1024];
    logic [`XLEN-1:0]       sregs [32];
    integer                 seed;
    logic [`XLEN-1:0]       miss_total = '0;

    // Model of the item in MEM
    logic                   m_we = 1'b0;
    logic [`REG_ADDR_W-1:0] m_dest = '0;
    logic [`XLEN-1:0]       m_val = '0;
    logic                   m_store = 1'b0;
    logic                   m_mis = 1'b0;
    logic [9:0]             m_addr = '0;
    logic [`XLEN-1:0]       m_data = '0;
    width_e                 m_width = W_BYTE;

    // Model of the item in WB
    logic                   w_we = 1'b0;
    logic [`REG_ADDR_W-1:0] w_dest = '0;
    logic [`XLEN-1:0]       w_val = '0;

    // Expected outputs for the current cycle
    logic                   exp_mem_we = 1'b0;
    logic [`REG_ADDR_W-1:0] exp_mem_dest = '0;
    logic                   exp_mis = 1'b0;
    logic                   exp_wb_we = 1'b0;
    logic [`REG_ADDR_W-1:0] exp_wb_dest = '0;
    logic [`XLEN-1:0]       exp_miss = '0;
    logic [`XLEN-1:0]       exp_rdata_a = '0;
    logic [`XLEN-1:0]       exp_rdata_b = '0;

    mem_wb_top dut (
        .clk          (clk),
        .reset        (reset),
        .valid_i      (valid),
        .mem_op_i     (mem_op),
        .funct3_i     (funct3),
        .rd_i         (rd),
        .alu_result_i (alu_result),
        .store_data_i (store_data),
        .raddr_a_i    (raddr_a),
        .raddr_b_i    (raddr_b),
        .rdata_a_o    (rdata_a),
        .rdata_b_o    (rdata_b),
        .mem_dest_o   (mem_dest),
        .mem_we_o     (mem_we),
        .wb_dest_o    (wb_dest),
        .wb_we_o      (wb_we),
        .misaligned_o (misaligned),
        .miss_count_o (miss_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Shadow memory rules
    ////////////////////////////////////////////////////////////////////////////

    // Little endian, halves and words already aligned here
    function automatic logic [`XLEN-1:0] expected_load(input logic [9:0] a,
                                                       input width_e width);
        logic [7:0]       b;
        logic [15:0]      h;
        logic [`XLEN-1:0] word;
        b    = smem[a];
        h    = {smem[a + 10'd1], smem[a]};
        word = {smem[{a[9:2], 2'd3}], smem[{a[9:2], 2'd2}],
                smem[{a[9:2], 2'd1}], smem[{a[9:2], 2'd0}]};
        case (width)
            W_BYTE:  return {{24{b[7]}}, b};
            W_BYTEU: return {24'd0, b};
            W_HALF:  return {{16{h[15]}}, h};
            W_HALFU: return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic commit_store(input logic [9:0] a, input logic [`XLEN-1:0] d,
                                input width_e width);
        case (width)
            W_BYTE, W_BYTEU: smem[a] = d[7:0];
            W_HALF, W_HALFU: begin
                smem[a]         = d[7:0];
                smem[a + 10'd1] = d[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    smem[{a[9:2], 2'(i)}] = d[8*i +: 8];
                end
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One instruction per falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic issue(input logic v, input mem_op_e op, input width_e width,
                         input logic [`REG_ADDR_W-1:0] dest,
                         input logic [`XLEN-1:0] alu, input logic [`XLEN-1:0] sdata);
        logic                   live;
        logic [`REG_ADDR_W-1:0] just_written;
        @(negedge clk);
        // Effects of the rising edge just passed
        just_written = w_we ? w_dest : '0;
        if (w_we) begin
            sregs[w_dest] = w_val;
        end
        if (m_store) begin
            commit_store(m_addr, m_data, m_width);
        end
        if (m_mis) begin
            miss_total = miss_total + 1;
        end
        w_we   = m_we;
        w_dest = m_dest;
        w_val  = m_val;
        // New item enters MEM
        m_mis   = v && (op == MEM_OP_LOAD || op == MEM_OP_STORE)
                  && (((width == W_HALF || width == W_HALFU) && alu[0])
                      || (width == W_WORD && alu[1:0] != 2'b00));
        live    = v && !m_mis;
        m_dest  = live ? dest : '0;
        m_we    = live && dest != '0 && (op == MEM_OP_NONE || op == MEM_OP_LOAD);
        m_store = live && op == MEM_OP_STORE;
        m_addr  = alu[9:0];
        m_data  = sdata;
        m_width = width;
        m_val   = (op == MEM_OP_LOAD) ? expected_load(alu[9:0], width) : alu;
        valid      = v;
        mem_op     = op;
        funct3     = width;
        rd         = dest;
        alu_result = alu;
        store_data = sdata;
        // Port A follows the register written on the last edge
        raddr_a    = just_written;
        raddr_b    = 5'($random(seed));
        exp_mem_we   = m_we;
        exp_mem_dest = m_dest;
        exp_mis      = m_mis;
        exp_wb_we    = w_we;
        exp_wb_dest  = w_dest;
        exp_miss     = miss_total;
        exp_rdata_a  = sregs[raddr_a];
        exp_rdata_b  = sregs[raddr_b];
    endtask

    task automatic random_step();
        logic [31:0]            r;
        logic [`XLEN-1:0]       addr;
        mem_op_e                op;
        width_e                 width;
        logic [`REG_ADDR_W-1:0] dest;
        r    = $random(seed);
        addr = $random(seed);
        op   = mem_op_e'(r[1:0]);
        case (r[4:2])
            3'd0, 3'd7: width = W_BYTE;
            3'd1, 3'd6: width = W_HALF;
            3'd2, 3'd5: width = W_WORD;
            3'd3:       width = W_BYTEU;
            default:    width = W_HALFU;
        endcase
        // x0 picked often
        dest = (r[7:5] == 3'd0) ? '0 : r[12:8];
        if (op == MEM_OP_LOAD || op == MEM_OP_STORE) begin
            addr[9:0] = WIN_BASE | {4'd0, addr[5:0]};
            // Mostly aligned, one in four left as is
            if (r[14:13] != 2'b00) begin
                if (width == W_HALF || width == W_HALFU) begin
                    addr[0] = 1'b0;
                end
                if (width == W_WORD) begin
                    addr[1:0] = 2'b00;
                end
            end
        end
        issue(r[17:15] != 3'd0, op, width, dest, addr, $random(seed));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks against the shadow model
    ////////////////////////////////////////////////////////////////////////////
    a_mem_hazard: assert property (@(posedge clk) disable iff (!reset)
        mem_we == exp_mem_we && mem_dest == exp_mem_dest)
        else stop_with_failure($sformatf("FAIL t=%0t: MEM we/dest %0b/%0d, expected %0b/%0d",
            $time, $sampled(mem_we), $sampled(mem_dest), exp_mem_we, exp_mem_dest));

    a_wb_hazard: assert property (@(posedge clk) disable iff (!reset)
        wb_we == exp_wb_we && wb_dest == exp_wb_dest)
        else stop_with_failure($sformatf("FAIL t=%0t: WB we/dest %0b/%0d, expected %0b/%0d",
            $time, $sampled(wb_we), $sampled(wb_dest), exp_wb_we, exp_wb_dest));

    // WB is MEM delayed by exactly one cycle
    a_wb_follows_mem: assert property (@(posedge clk) disable iff (!reset)
        1'b1 |=> wb_we == $past(mem_we) && wb_dest == $past(mem_dest))
        else stop_with_failure($sformatf("FAIL t=%0t: WB does not follow MEM", $time));

    a_port_a: assert property (@(posedge clk) disable iff (!reset) rdata_a == exp_rdata_a)
        else stop_with_failure($sformatf("FAIL t=%0t: port A x%0d = %h, expected %h",
            $time, $sampled(raddr_a), $sampled(rdata_a), exp_rdata_a));

    a_port_b: assert property (@(posedge clk) disable iff (!reset) rdata_b == exp_rdata_b)
        else stop_with_failure($sformatf("FAIL t=%0t: port B x%0d = %h, expected %h",
            $time, $sampled(raddr_b), $sampled(rdata_b), exp_rdata_b));

    a_x0_zero: assert property (@(posedge clk) raddr_a == '0 |-> rdata_a == '0)
        else stop_with_failure($sformatf("FAIL t=%0t: x0 read nonzero", $time));

    a_misaligned: assert property (@(posedge clk) disable iff (!reset) misaligned == exp_mis)
        else stop_with_failure($sformatf("FAIL t=%0t: misaligned %0b, expected %0b",
            $time, $sampled(misaligned), exp_mis));

    a_miss_count: assert property (@(posedge clk) disable iff (!reset) miss_count == exp_miss)
        else stop_with_failure($sformatf("FAIL t=%0t: miss count %0d, expected %0d",
            $time, $sampled(miss_count), exp_miss));

    // During reset and on the first cycle after it
    a_reset_state: assert property (@(posedge clk)
        (!reset || $rose(reset)) |-> !wb_we && rdata_a == '0 && rdata_b == '0)
        else stop_with_failure($sformatf("FAIL t=%0t: state not cleared by reset", $time));

    initial begin
        logic [`XLEN-1:0] fill_addr;
        int               drain;
        seed       = 28;
        reset      = 1'b0;
        valid      = 1'b0;
        mem_op     = MEM_OP_NONE;
        funct3     = W_BYTE;
        rd         = '0;
        alu_result = '0;
        store_data = '0;
        // Real registers on both ports so cleared contents are visible
        raddr_a    = 5'd31;
        raddr_b    = 5'd1;
        for (int i = 0; i < 32; i++) begin
            sregs[i] = '0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b1;
        // Word stores over the window, random upper bits exercise the wrap
        for (int i = 0; i < 16; i++) begin
            fill_addr      = $random(seed);
            fill_addr[9:0] = WIN_BASE + 10'(4 * i);
            issue(1'b1, MEM_OP_STORE, W_WORD, '0, fill_addr, $random(seed));
        end
        repeat (NUM_RANDOM) random_step();
        // Idle until both stages are empty
        drain = 0;
        issue(1'b0, MEM_OP_NONE, W_BYTE, '0, '0, '0);
        @(posedge clk);
        while ((wb_we || mem_we) && drain < DRAIN_LIMIT) begin
            drain++;
            issue(1'b0, MEM_OP_NONE, W_BYTE, '0, '0, '0);
            @(posedge clk);
        end
        if (wb_we || mem_we) begin
            stop_with_failure("Timeout: pipeline still busy after idle cycles");
        end else begin
            @(negedge clk);
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- all.f
+incdir+source
source/backend_pkg.sv
source/mem_control.sv
source/mem_stage.sv
source/data_memory.sv
source/writeback_stage.sv
source/register_file.sv
source/mem_wb_top.sv
verification/mem_wb_tb.sv

//--- Makefile
# Verilator simulation of the MEM/WB back end

VERILATOR ?= verilator
TOP       ?= mem_wb_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
